//--- common/icb_pkg.sv
// ICB bus widths and address map
package icb_pkg;

  localparam int XLEN   = 32;
  localparam int ADDR_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [XLEN-1:0]   data_t;

  //////////////////////////////
  // Target regions
  //////////////////////////////

  localparam addr_t CLINT_BASE = 32'h0200_0000;
  localparam addr_t PLIC_BASE  = 32'h0C00_0000;
  localparam addr_t GPIO_BASE  = 32'h1001_2000;

  // Upper 16 address bits pick the region
  localparam addr_t REGION_MASK = 32'hFFFF_0000;

  typedef enum logic [1:0] {
    TGT_CLINT,
    TGT_PLIC,
    TGT_GPIO,
    TGT_NONE
  } target_e;

endpackage

//--- common/perip_pkg.sv
// Peripheral register map and inspect layout
package perip_pkg;

  // Register offset inside a target region
  localparam int OFS_W = 16;
  typedef logic [OFS_W-1:0] ofs_t;

  //////////////////////////////
  // CLINT
  //////////////////////////////

  localparam ofs_t CLINT_MSIP        = 16'h0000;
  localparam ofs_t CLINT_MTIMECMP_LO = 16'h4000;
  localparam ofs_t CLINT_MTIMECMP_HI = 16'h4004;
  localparam ofs_t CLINT_MTIME_LO    = 16'hBFF8;
  localparam ofs_t CLINT_MTIME_HI    = 16'hBFFC;

  //////////////////////////////
  // PLIC
  //////////////////////////////

  localparam ofs_t PLIC_CLAIM   = 16'h0004;
  localparam ofs_t PLIC_PENDING = 16'h1000;
  localparam ofs_t PLIC_ENABLE  = 16'h2000;

  // Source ids start at 1
  // Id 0 means no interrupt
  localparam int NUM_SRC  = 3;
  localparam int SRC_WDG  = 1;
  localparam int SRC_RTC  = 2;
  localparam int SRC_GPIO = 3;
  localparam int SRC_ID_W = $clog2(NUM_SRC + 1);

  //////////////////////////////
  // GPIO
  //////////////////////////////

  localparam ofs_t GPIO_INPUT_VAL  = 16'h0000;
  localparam ofs_t GPIO_OUTPUT_EN  = 16'h0008;
  localparam ofs_t GPIO_OUTPUT_VAL = 16'h000C;
  localparam ofs_t GPIO_HIGH_IE    = 16'h0028;

  // Inspect vector fields from the LSB up
  //   address low bits, cmd valid/ready, rsp valid/ready,
  //   jtag clk, ext irq, por rst, 32k clk, sft irq, tmr irq
  localparam int INSP_ADDR_W = 22;
  localparam int INSP_W      = 32;

endpackage

//--- common/icb_if.sv
// ICB command and response channels
interface icb_if import icb_pkg::*; ();

  // Command channel
  logic  cmd_valid;
  logic  cmd_ready;
  addr_t addr;
  logic  read;
  data_t wdata;

  // Response channel
  logic  rsp_valid;
  logic  rsp_ready;
  logic  rsp_err;
  data_t rsp_data;

  modport master (
    output cmd_valid, addr, read, wdata, rsp_ready,
    input  cmd_ready, rsp_valid, rsp_err, rsp_data
  );

  modport slave (
    input  cmd_valid, addr, read, wdata, rsp_ready,
    output cmd_ready, rsp_valid, rsp_err, rsp_data
  );

endinterface

//--- icb_fabric/icb_splitter.sv
// ICB address decoder and target select
module icb_splitter
  import icb_pkg::*;
(
  input  logic  hfclk,
  input  logic  reset,

  input  logic  icb_cmd_valid,
  output logic  icb_cmd_ready,
  input  addr_t icb_cmd_addr,
  input  logic  icb_cmd_read,
  input  data_t icb_cmd_wdata,
  output logic  icb_rsp_valid,
  input  logic  icb_rsp_ready,
  output logic  icb_rsp_err,
  output data_t icb_rsp_rdata,

  icb_if.master clint_bus,
  icb_if.master plic_bus,
  icb_if.master gpio_bus,

  output addr_t last_addr
);

  target_e cmd_tgt;
  target_e pend_tgt;
  logic    rsp_pend;
  logic    rsp_fire;
  logic    cmd_fire;
  logic    can_accept;
  logic    tgt_ready;

  function automatic logic region_hit(addr_t addr, addr_t base);
    return (addr & REGION_MASK) == (base & REGION_MASK);
  endfunction

  //////////////////////////////
  // Command side
  //////////////////////////////

  always_comb begin
    if (region_hit(icb_cmd_addr, CLINT_BASE))
      cmd_tgt = TGT_CLINT;
    else if (region_hit(icb_cmd_addr, PLIC_BASE))
      cmd_tgt = TGT_PLIC;
    else if (region_hit(icb_cmd_addr, GPIO_BASE))
      cmd_tgt = TGT_GPIO;
    else
      cmd_tgt = TGT_NONE;
  end

  // Only one response in flight
  // A new command may follow its transfer
  assign rsp_fire   = icb_rsp_valid & icb_rsp_ready;
  assign can_accept = ~rsp_pend | rsp_fire;

  always_comb begin
    case (cmd_tgt)
      TGT_CLINT: tgt_ready = clint_bus.cmd_ready;
      TGT_PLIC:  tgt_ready = plic_bus.cmd_ready;
      TGT_GPIO:  tgt_ready = gpio_bus.cmd_ready;
      default:   tgt_ready = 1'b1;
    endcase
  end

  assign icb_cmd_ready = can_accept & tgt_ready;
  assign cmd_fire      = icb_cmd_valid & icb_cmd_ready;

  assign clint_bus.cmd_valid = icb_cmd_valid & can_accept & (cmd_tgt == TGT_CLINT);
  assign plic_bus.cmd_valid  = icb_cmd_valid & can_accept & (cmd_tgt == TGT_PLIC);
  assign gpio_bus.cmd_valid  = icb_cmd_valid & can_accept & (cmd_tgt == TGT_GPIO);

  assign clint_bus.addr  = icb_cmd_addr;
  assign clint_bus.read  = icb_cmd_read;
  assign clint_bus.wdata = icb_cmd_wdata;
  assign plic_bus.addr   = icb_cmd_addr;
  assign plic_bus.read   = icb_cmd_read;
  assign plic_bus.wdata  = icb_cmd_wdata;
  assign gpio_bus.addr   = icb_cmd_addr;
  assign gpio_bus.read   = icb_cmd_read;
  assign gpio_bus.wdata  = icb_cmd_wdata;

  //////////////////////////////
  // Response side
  //////////////////////////////

  always_comb begin
    icb_rsp_valid = 1'b0;
    icb_rsp_err   = 1'b0;
    icb_rsp_rdata = '0;
    case (pend_tgt)
      TGT_CLINT: begin
        icb_rsp_valid = rsp_pend & clint_bus.rsp_valid;
        icb_rsp_err   = clint_bus.rsp_err;
        icb_rsp_rdata = clint_bus.rsp_data;
      end
      TGT_PLIC: begin
        icb_rsp_valid = rsp_pend & plic_bus.rsp_valid;
        icb_rsp_err   = plic_bus.rsp_err;
        icb_rsp_rdata = plic_bus.rsp_data;
      end
      TGT_GPIO: begin
        icb_rsp_valid = rsp_pend & gpio_bus.rsp_valid;
        icb_rsp_err   = gpio_bus.rsp_err;
        icb_rsp_rdata = gpio_bus.rsp_data;
      end
      default: begin
        // Unmapped address, answered here
        icb_rsp_valid = rsp_pend;
        icb_rsp_err   = 1'b1;
      end
    endcase
  end

  assign clint_bus.rsp_ready = icb_rsp_ready & rsp_pend & (pend_tgt == TGT_CLINT);
  assign plic_bus.rsp_ready  = icb_rsp_ready & rsp_pend & (pend_tgt == TGT_PLIC);
  assign gpio_bus.rsp_ready  = icb_rsp_ready & rsp_pend & (pend_tgt == TGT_GPIO);

  always_ff @(posedge hfclk) begin
    if (reset) begin
      rsp_pend  <= 1'b0;
      pend_tgt  <= TGT_NONE;
      last_addr <= '0;
    end else if (cmd_fire) begin
      rsp_pend  <= 1'b1;
      pend_tgt  <= cmd_tgt;
      last_addr <= icb_cmd_addr;
    end else if (rsp_fire) begin
      rsp_pend  <= 1'b0;
    end
  end

  one_target_a: assert property (@(posedge hfclk) disable iff (reset)
    $onehot0({clint_bus.cmd_valid, plic_bus.cmd_valid, gpio_bus.cmd_valid}));

endmodule

//--- perips/clint.sv
// Core-local interruptor
module clint
  import icb_pkg::*;
  import perip_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic hfclk,
  input  logic reset,
  input  logic tm_stop,
  input  logic rtc_toggle,
  icb_if.slave bus,
  output logic sft_irq,
  output logic tmr_irq
);

  logic [SYNC_STAGES-1:0] toggle_sync;
  logic                   toggle_q;
  logic                   tick;
  logic [63:0]            mtime;
  logic [63:0]            mtimecmp;
  logic                   msip;
  ofs_t                   ofs;
  logic                   cmd_fire;
  data_t                  rd_data;
  logic                   rd_err;

  //////////////////////////////
  // RTC toggle edge detect
  //////////////////////////////

  always_ff @(posedge hfclk) begin
    if (reset) begin
      toggle_sync <= '0;
      toggle_q    <= 1'b0;
    end else begin
      toggle_sync <= (toggle_sync << 1) | SYNC_STAGES'(rtc_toggle);
      toggle_q    <= toggle_sync[SYNC_STAGES-1];
    end
  end

  assign tick = toggle_sync[SYNC_STAGES-1] & ~toggle_q;

  //////////////////////////////
  // Registers
  //////////////////////////////

  assign ofs      = bus.addr[OFS_W-1:0] - CLINT_BASE[OFS_W-1:0];
  assign cmd_fire = bus.cmd_valid & bus.cmd_ready;

  always_ff @(posedge hfclk) begin
    if (reset) begin
      msip     <= 1'b0;
      mtime    <= '0;
      mtimecmp <= '1;
    end else begin
      if (tick && !tm_stop)
        mtime <= mtime + 64'd1;
      // Bus write overrides the count
      if (cmd_fire && !bus.read) begin
        case (ofs)
          CLINT_MSIP:        msip           <= bus.wdata[0];
          CLINT_MTIMECMP_LO: mtimecmp[31:0]  <= bus.wdata;
          CLINT_MTIMECMP_HI: mtimecmp[63:32] <= bus.wdata;
          CLINT_MTIME_LO:    mtime[31:0]     <= bus.wdata;
          CLINT_MTIME_HI:    mtime[63:32]    <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (ofs)
      CLINT_MSIP:        rd_data = data_t'(msip);
      CLINT_MTIMECMP_LO: rd_data = mtimecmp[31:0];
      CLINT_MTIMECMP_HI: rd_data = mtimecmp[63:32];
      CLINT_MTIME_LO:    rd_data = mtime[31:0];
      CLINT_MTIME_HI:    rd_data = mtime[63:32];
      default:           rd_err  = 1'b1;
    endcase
  end

  assign sft_irq = msip;
  assign tmr_irq = mtime >= mtimecmp;

  //////////////////////////////
  // Response
  //////////////////////////////

  assign bus.cmd_ready = ~bus.rsp_valid | bus.rsp_ready;

  always_ff @(posedge hfclk) begin
    if (reset)
      bus.rsp_valid <= 1'b0;
    else if (cmd_fire)
      bus.rsp_valid <= 1'b1;
    else if (bus.rsp_ready)
      bus.rsp_valid <= 1'b0;
  end

  always_ff @(posedge hfclk) begin
    if (cmd_fire) begin
      bus.rsp_data <= bus.read ? rd_data : '0;
      bus.rsp_err  <= rd_err;
    end
  end

  rsp_hold_a: assert property (@(posedge hfclk) disable iff (reset)
    bus.rsp_valid && !bus.rsp_ready |=> bus.rsp_valid && $stable(bus.rsp_data));

endmodule

//--- perips/plic.sv
// Reduced platform interrupt controller
module plic
  import icb_pkg::*;
  import perip_pkg::*;
(
  input  logic hfclk,
  input  logic reset,
  input  logic wdg_irq,
  input  logic rtc_irq,
  input  logic gpio_irq,
  icb_if.slave bus,
  output logic ext_irq
);

  // Bit n stands for source id n
  logic [NUM_SRC:1]    src;
  logic [NUM_SRC:1]    pending;
  logic [NUM_SRC:1]    enable;
  logic [NUM_SRC:1]    hit;
  logic [NUM_SRC:1]    claim_clr;
  logic [SRC_ID_W-1:0] claim_id;
  ofs_t                ofs;
  logic                cmd_fire;
  logic                claim_fire;
  data_t               rd_data;
  logic                rd_err;

  assign src[SRC_WDG]  = wdg_irq;
  assign src[SRC_RTC]  = rtc_irq;
  assign src[SRC_GPIO] = gpio_irq;

  assign hit     = pending & enable;
  assign ext_irq = |hit;

  // Lowest id wins
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC; i >= 1; i--) begin
      if (hit[i])
        claim_id = SRC_ID_W'(i);
    end
  end

  assign ofs        = bus.addr[OFS_W-1:0] - PLIC_BASE[OFS_W-1:0];
  assign cmd_fire   = bus.cmd_valid & bus.cmd_ready;
  assign claim_fire = cmd_fire & bus.read & (ofs == PLIC_CLAIM);

  always_comb begin
    claim_clr = '0;
    if (claim_fire && claim_id != '0)
      claim_clr[claim_id] = 1'b1;
  end

  always_ff @(posedge hfclk) begin
    if (reset) begin
      pending <= '0;
      enable  <= '0;
    end else begin
      // A source still high sets its bit again
      pending <= (pending & ~claim_clr) | src;
      if (cmd_fire && !bus.read && ofs == PLIC_ENABLE)
        enable <= bus.wdata[NUM_SRC:1];
    end
  end

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (ofs)
      PLIC_CLAIM:   rd_data = data_t'(claim_id);
      PLIC_PENDING: rd_data = data_t'({pending, 1'b0});
      PLIC_ENABLE:  rd_data = data_t'({enable, 1'b0});
      default:      rd_err  = 1'b1;
    endcase
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  assign bus.cmd_ready = ~bus.rsp_valid | bus.rsp_ready;

  always_ff @(posedge hfclk) begin
    if (reset)
      bus.rsp_valid <= 1'b0;
    else if (cmd_fire)
      bus.rsp_valid <= 1'b1;
    else if (bus.rsp_ready)
      bus.rsp_valid <= 1'b0;
  end

  always_ff @(posedge hfclk) begin
    if (cmd_fire) begin
      bus.rsp_data <= bus.read ? rd_data : '0;
      bus.rsp_err  <= rd_err;
    end
  end

endmodule

//--- perips/gpio.sv
// GPIO register block
module gpio
  import icb_pkg::*;
  import perip_pkg::*;
#(
  parameter int GPIO_W      = 32,
  parameter int SYNC_STAGES = 2
) (
  input  logic              hfclk,
  input  logic              reset,
  input  logic              inspect_mode,
  input  logic [GPIO_W-1:0] inspect_vec,
  input  logic [GPIO_W-1:0] pad_in,
  icb_if.slave              bus,
  output logic [GPIO_W-1:0] pad_out,
  output logic [GPIO_W-1:0] pad_oe,
  output logic              gpio_irq
);

  logic [GPIO_W-1:0] sync_q [SYNC_STAGES];
  logic [GPIO_W-1:0] in_val;
  logic [GPIO_W-1:0] out_en;
  logic [GPIO_W-1:0] out_val;
  logic [GPIO_W-1:0] high_ie;
  ofs_t              ofs;
  logic              cmd_fire;
  data_t             rd_data;
  logic              rd_err;

  // Pad input synchronizer
  always_ff @(posedge hfclk) begin
    sync_q[0] <= pad_in;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  assign in_val   = sync_q[SYNC_STAGES-1];
  assign gpio_irq = |(in_val & high_ie);

  //////////////////////////////
  // Registers
  //////////////////////////////

  assign ofs      = bus.addr[OFS_W-1:0] - GPIO_BASE[OFS_W-1:0];
  assign cmd_fire = bus.cmd_valid & bus.cmd_ready;

  always_ff @(posedge hfclk) begin
    if (reset) begin
      out_en  <= '0;
      out_val <= '0;
      high_ie <= '0;
    end else if (cmd_fire && !bus.read) begin
      case (ofs)
        GPIO_OUTPUT_EN:  out_en  <= bus.wdata[GPIO_W-1:0];
        GPIO_OUTPUT_VAL: out_val <= bus.wdata[GPIO_W-1:0];
        GPIO_HIGH_IE:    high_ie <= bus.wdata[GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (ofs)
      GPIO_INPUT_VAL:  rd_data = data_t'(in_val);
      GPIO_OUTPUT_EN:  rd_data = data_t'(out_en);
      GPIO_OUTPUT_VAL: rd_data = data_t'(out_val);
      GPIO_HIGH_IE:    rd_data = data_t'(high_ie);
      default:         rd_err  = 1'b1;
    endcase
  end

  // Inspect mode takes over every pad
  // Registers keep their values
  assign pad_oe  = inspect_mode ? '1 : out_en;
  assign pad_out = inspect_mode ? inspect_vec : out_val;

  //////////////////////////////
  // Response
  //////////////////////////////

  assign bus.cmd_ready = ~bus.rsp_valid | bus.rsp_ready;

  always_ff @(posedge hfclk) begin
    if (reset)
      bus.rsp_valid <= 1'b0;
    else if (cmd_fire)
      bus.rsp_valid <= 1'b1;
    else if (bus.rsp_ready)
      bus.rsp_valid <= 1'b0;
  end

  always_ff @(posedge hfclk) begin
    if (cmd_fire) begin
      bus.rsp_data <= bus.read ? rd_data : '0;
      bus.rsp_err  <= rd_err;
    end
  end

endmodule

//--- hdl/subsys_main.sv
// Always-on subsystem top level
module subsys_main
  import icb_pkg::*;
  import perip_pkg::*;
#(
  parameter int GPIO_W      = 32,
  parameter int SYNC_STAGES = 2
) (
  input  logic              hfclk,
  input  logic              reset,

  input  logic              inspect_mode,
  input  logic              inspect_por_rst,
  input  logic              inspect_32k_clk,
  input  logic              inspect_jtag_clk,

  input  logic              aon_wdg_irq_a,
  input  logic              aon_rtc_irq_a,
  input  logic              aon_rtc_toggle_a,
  input  logic              tm_stop,

  // External ICB master
  input  logic              icb_cmd_valid,
  output logic              icb_cmd_ready,
  input  addr_t             icb_cmd_addr,
  input  logic              icb_cmd_read,
  input  data_t             icb_cmd_wdata,
  output logic              icb_rsp_valid,
  input  logic              icb_rsp_ready,
  output logic              icb_rsp_err,
  output data_t             icb_rsp_rdata,

  input  logic [GPIO_W-1:0] gpio_a_i_ival,
  output logic [GPIO_W-1:0] gpio_a_o_oval,
  output logic [GPIO_W-1:0] gpio_a_o_oe,

  output logic              ext_irq,
  output logic              sft_irq,
  output logic              tmr_irq
);

  icb_if clint_bus ();
  icb_if plic_bus ();
  icb_if gpio_bus ();

  addr_t             last_addr;
  logic              gpio_irq;
  logic [INSP_W-1:0] insp_vec;

  // Debug view driven onto GPIO-A in inspect mode
  assign insp_vec = {
    tmr_irq,
    sft_irq,
    inspect_32k_clk,
    inspect_por_rst,
    ext_irq,
    inspect_jtag_clk,
    icb_rsp_ready,
    icb_rsp_valid,
    icb_cmd_ready,
    icb_cmd_valid,
    last_addr[INSP_ADDR_W-1:0]
  };

  icb_splitter u_icb_splitter (
    .hfclk         (hfclk),
    .reset         (reset),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd_addr  (icb_cmd_addr),
    .icb_cmd_read  (icb_cmd_read),
    .icb_cmd_wdata (icb_cmd_wdata),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp_err   (icb_rsp_err),
    .icb_rsp_rdata (icb_rsp_rdata),
    .clint_bus     (clint_bus),
    .plic_bus      (plic_bus),
    .gpio_bus      (gpio_bus),
    .last_addr     (last_addr)
  );

  clint #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_clint (
    .hfclk      (hfclk),
    .reset      (reset),
    .tm_stop    (tm_stop),
    .rtc_toggle (aon_rtc_toggle_a),
    .bus        (clint_bus),
    .sft_irq    (sft_irq),
    .tmr_irq    (tmr_irq)
  );

  plic u_plic (
    .hfclk    (hfclk),
    .reset    (reset),
    .wdg_irq  (aon_wdg_irq_a),
    .rtc_irq  (aon_rtc_irq_a),
    .gpio_irq (gpio_irq),
    .bus      (plic_bus),
    .ext_irq  (ext_irq)
  );

  gpio #(
    .GPIO_W      (GPIO_W),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_gpio_a (
    .hfclk        (hfclk),
    .reset        (reset),
    .inspect_mode (inspect_mode),
    .inspect_vec  (GPIO_W'(insp_vec)),
    .pad_in       (gpio_a_i_ival),
    .bus          (gpio_bus),
    .pad_out      (gpio_a_o_oval),
    .pad_oe       (gpio_a_o_oe),
    .gpio_irq     (gpio_irq)
  );

endmodule

//--- verification/tb_subsys_tasks.svh
// Bus access and directed tests
`ifndef TB_SUBSYS_TASKS_SVH
`define TB_SUBSYS_TASKS_SVH

function automatic addr_t reg_addr(input addr_t base, input ofs_t ofs);
  return base | addr_t'(ofs);
endfunction

//////////////////////////////
// Bus access
//////////////////////////////

task automatic drive_cmd(input addr_t addr, input logic rd, input data_t wdata);
  @(posedge hfclk);
  icb_cmd_valid <= 1'b1;
  icb_cmd_addr  <= addr;
  icb_cmd_read  <= rd;
  icb_cmd_wdata <= wdata;
endtask

// Returns on the transfer edge
task automatic wait_accept();
  int n;
  n = 0;
  @(negedge hfclk);
  while (!icb_cmd_ready) begin
    n++;
    if (n > TIMEOUT)
      report_timeout("command ready");
    @(negedge hfclk);
  end
  @(posedge hfclk);
  icb_cmd_valid <= 1'b0;
endtask

// Latency counted in cycles after the transfer edge
task automatic wait_rsp(output data_t rdata, output logic err, output int lat);
  lat = 1;
  @(negedge hfclk);
  while (!icb_rsp_valid) begin
    lat++;
    if (lat > TIMEOUT)
      report_timeout("response valid");
    @(negedge hfclk);
  end
  rdata = icb_rsp_rdata;
  err   = icb_rsp_err;
endtask

task automatic bus_write(input addr_t addr, input data_t wdata);
  data_t rdata;
  logic  err;
  int    lat;
  drive_cmd(addr, 1'b0, wdata);
  wait_accept();
  wait_rsp(rdata, err, lat);
  expect_word("write latency", data_t'(lat), 32'd1);
  expect_bit("write rsp_err", err, 1'b0);
endtask

task automatic bus_read(input addr_t addr, output data_t rdata);
  logic err;
  int   lat;
  drive_cmd(addr, 1'b1, '0);
  wait_accept();
  wait_rsp(rdata, err, lat);
  expect_word("read latency", data_t'(lat), 32'd1);
  expect_bit("read rsp_err", err, 1'b0);
endtask

task automatic pulse_rtc_toggle();
  @(posedge hfclk);
  aon_rtc_toggle_a <= 1'b1;
  repeat (4) @(posedge hfclk);
  aon_rtc_toggle_a <= 1'b0;
  repeat (4) @(posedge hfclk);
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic register_round_trip();
  data_t en;
  data_t val;
  data_t ie;
  data_t cmp_lo;
  data_t cmp_hi;
  data_t rd;
  rand_word(en);
  rand_word(val);
  rand_word(ie);
  rand_word(cmp_lo);
  rand_word(cmp_hi);
  bus_write(reg_addr(GPIO_BASE, GPIO_OUTPUT_EN), en);
  bus_write(reg_addr(GPIO_BASE, GPIO_OUTPUT_VAL), val);
  bus_write(reg_addr(GPIO_BASE, GPIO_HIGH_IE), ie);
  bus_write(reg_addr(CLINT_BASE, CLINT_MTIMECMP_LO), cmp_lo);
  bus_write(reg_addr(CLINT_BASE, CLINT_MTIMECMP_HI), cmp_hi);
  bus_read(reg_addr(GPIO_BASE, GPIO_OUTPUT_EN), rd);
  expect_word("OUTPUT_EN", rd, en);
  bus_read(reg_addr(GPIO_BASE, GPIO_OUTPUT_VAL), rd);
  expect_word("OUTPUT_VAL", rd, val);
  bus_read(reg_addr(GPIO_BASE, GPIO_HIGH_IE), rd);
  expect_word("HIGH_IE", rd, ie);
  bus_read(reg_addr(CLINT_BASE, CLINT_MTIMECMP_LO), rd);
  expect_word("MTIMECMP_LO", rd, cmp_lo);
  bus_read(reg_addr(CLINT_BASE, CLINT_MTIMECMP_HI), rd);
  expect_word("MTIMECMP_HI", rd, cmp_hi);
  expect_word("pad oe", gpio_a_o_oe, en);
  expect_word("pad out", gpio_a_o_oval, val);
  // Keep the GPIO interrupt quiet for the PLIC test
  bus_write(reg_addr(GPIO_BASE, GPIO_HIGH_IE), '0);
endtask

task automatic decode_error_backpressure();
  data_t w;
  data_t rd;
  logic  err;
  int    lat;
  drive_cmd(32'h2000_0000, 1'b1, '0);
  wait_accept();
  wait_rsp(rd, err, lat);
  expect_word("unmapped latency", data_t'(lat), 32'd1);
  expect_bit("unmapped rsp_err", err, 1'b1);
  expect_word("unmapped rdata", rd, '0);

  rand_word(w);
  bus_write(reg_addr(GPIO_BASE, GPIO_OUTPUT_VAL), w);
  drive_cmd(reg_addr(GPIO_BASE, GPIO_OUTPUT_VAL), 1'b1, '0);
  icb_rsp_ready <= 1'b0;
  wait_accept();
  wait_rsp(rd, err, lat);
  expect_word("held read", rd, w);

  // Second command waits behind the stalled response
  drive_cmd(reg_addr(CLINT_BASE, CLINT_MSIP), 1'b1, '0);
  for (int i = 0; i < 6; i++) begin
    @(negedge hfclk);
    expect_bit("held rsp_valid", icb_rsp_valid, 1'b1);
    expect_word("held rsp_rdata", icb_rsp_rdata, w);
    expect_bit("cmd_ready under stall", icb_cmd_ready, 1'b0);
  end
  @(posedge hfclk);
  icb_rsp_ready <= 1'b1;
  wait_accept();
  wait_rsp(rd, err, lat);
  expect_word("queued latency", data_t'(lat), 32'd1);
  expect_word("queued MSIP", rd, '0);
endtask

task automatic clint_interrupts();
  data_t rd;
  int    n;
  bus_write(reg_addr(CLINT_BASE, CLINT_MSIP), 32'd1);
  expect_bit("sft_irq set", sft_irq, 1'b1);
  bus_write(reg_addr(CLINT_BASE, CLINT_MSIP), 32'd0);
  expect_bit("sft_irq clear", sft_irq, 1'b0);

  bus_write(reg_addr(CLINT_BASE, CLINT_MTIME_LO), '0);
  bus_write(reg_addr(CLINT_BASE, CLINT_MTIME_HI), '0);
  bus_write(reg_addr(CLINT_BASE, CLINT_MTIMECMP_HI), '0);
  bus_write(reg_addr(CLINT_BASE, CLINT_MTIMECMP_LO), 32'd3);
  expect_bit("tmr_irq before ticks", tmr_irq, 1'b0);
  pulse_rtc_toggle();
  pulse_rtc_toggle();
  @(negedge hfclk);
  expect_bit("tmr_irq after two ticks", tmr_irq, 1'b0);
  pulse_rtc_toggle();
  n = 0;
  @(negedge hfclk);
  while (!tmr_irq) begin
    n++;
    if (n > TIMEOUT)
      report_timeout("timer interrupt");
    @(negedge hfclk);
  end
  bus_read(reg_addr(CLINT_BASE, CLINT_MTIME_LO), rd);
  expect_word("MTIME_LO", rd, 32'd3);
  bus_read(reg_addr(CLINT_BASE, CLINT_MTIME_HI), rd);
  expect_word("MTIME_HI", rd, '0);

  // Frozen count
  @(posedge hfclk);
  tm_stop <= 1'b1;
  pulse_rtc_toggle();
  pulse_rtc_toggle();
  bus_read(reg_addr(CLINT_BASE, CLINT_MTIME_LO), rd);
  expect_word("MTIME_LO stopped", rd, 32'd3);
  @(posedge hfclk);
  tm_stop <= 1'b0;
endtask

task automatic plic_claims();
  data_t rd;
  @(posedge hfclk);
  aon_wdg_irq_a <= 1'b1;
  aon_rtc_irq_a <= 1'b1;
  @(posedge hfclk);
  aon_wdg_irq_a <= 1'b0;
  aon_rtc_irq_a <= 1'b0;
  bus_read(reg_addr(PLIC_BASE, PLIC_PENDING), rd);
  expect_word("PENDING", rd, 32'h0000_0006);
  expect_bit("ext_irq disabled", ext_irq, 1'b0);
  bus_write(reg_addr(PLIC_BASE, PLIC_ENABLE), 32'h0000_000E);
  expect_bit("ext_irq enabled", ext_irq, 1'b1);
  bus_read(reg_addr(PLIC_BASE, PLIC_CLAIM), rd);
  expect_word("first claim", rd, data_t'(SRC_WDG));
  bus_read(reg_addr(PLIC_BASE, PLIC_CLAIM), rd);
  expect_word("second claim", rd, data_t'(SRC_RTC));
  bus_read(reg_addr(PLIC_BASE, PLIC_CLAIM), rd);
  expect_word("empty claim", rd, '0);
  expect_bit("ext_irq after claims", ext_irq, 1'b0);
endtask

task automatic gpio_input_irq();
  data_t pads;
  data_t ie;
  data_t rd;
  int    n;
  rand_word(pads);
  if (pads == '0)
    pads = 32'd1;
  // Lowest pad driven high
  ie = pads & (~pads + 32'd1);
  @(posedge hfclk);
  gpio_a_i_ival <= pads;
  repeat (SYNC_STAGES + 1) @(posedge hfclk);
  bus_read(reg_addr(GPIO_BASE, GPIO_INPUT_VAL), rd);
  expect_word("INPUT_VAL", rd, pads);

  bus_write(reg_addr(GPIO_BASE, GPIO_HIGH_IE), ie);
  n = 0;
  @(negedge hfclk);
  while (!ext_irq) begin
    n++;
    if (n > TIMEOUT)
      report_timeout("GPIO external interrupt");
    @(negedge hfclk);
  end
  bus_read(reg_addr(PLIC_BASE, PLIC_CLAIM), rd);
  expect_word("GPIO claim", rd, data_t'(SRC_GPIO));
  // Source still high re-arms pending until HIGH_IE drops
  bus_write(reg_addr(GPIO_BASE, GPIO_HIGH_IE), '0);
  bus_read(reg_addr(PLIC_BASE, PLIC_CLAIM), rd);
  expect_word("GPIO re-claim", rd, data_t'(SRC_GPIO));
  bus_read(reg_addr(PLIC_BASE, PLIC_CLAIM), rd);
  expect_word("claim after GPIO", rd, '0);
endtask

task automatic inspect_override();
  data_t en;
  data_t val;
  data_t exp;
  addr_t last;
  rand_word(en);
  rand_word(val);
  last = reg_addr(GPIO_BASE, GPIO_OUTPUT_VAL);
  bus_write(reg_addr(CLINT_BASE, CLINT_MSIP), 32'd1);
  bus_write(reg_addr(GPIO_BASE, GPIO_OUTPUT_EN), en);
  bus_write(last, val);

  @(posedge hfclk);
  inspect_mode     <= 1'b1;
  inspect_por_rst  <= 1'b1;
  inspect_32k_clk  <= 1'b0;
  inspect_jtag_clk <= 1'b1;
  @(negedge hfclk);
  // Idle bus, timer and software interrupts up, external down
  exp = {1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1,
         1'b1, 1'b0, 1'b1, 1'b0, last[INSP_ADDR_W-1:0]};
  expect_word("inspect oe", gpio_a_o_oe, '1);
  expect_word("inspect vector", gpio_a_o_oval, exp);

  @(posedge hfclk);
  inspect_por_rst <= 1'b0;
  inspect_32k_clk <= 1'b1;
  @(negedge hfclk);
  exp[28] = 1'b0;
  exp[29] = 1'b1;
  expect_word("inspect vector swapped", gpio_a_o_oval, exp);

  @(posedge hfclk);
  inspect_mode <= 1'b0;
  @(negedge hfclk);
  expect_word("pad oe restored", gpio_a_o_oe, en);
  expect_word("pad out restored", gpio_a_o_oval, val);
  bus_write(reg_addr(CLINT_BASE, CLINT_MSIP), 32'd0);
endtask

`endif

//--- verification/tb_subsys_main.sv
// Always-on subsystem testbench
module tb_subsys_main
  import icb_pkg::*;
  import perip_pkg::*;
();

  localparam int GPIO_W      = 32;
  localparam int SYNC_STAGES = 2;
  localparam int TIMEOUT     = 20;

  logic              hfclk;
  logic              reset;
  logic              inspect_mode;
  logic              inspect_por_rst;
  logic              inspect_32k_clk;
  logic              inspect_jtag_clk;
  logic              aon_wdg_irq_a;
  logic              aon_rtc_irq_a;
  logic              aon_rtc_toggle_a;
  logic              tm_stop;
  logic              icb_cmd_valid;
  logic              icb_cmd_ready;
  addr_t             icb_cmd_addr;
  logic              icb_cmd_read;
  data_t             icb_cmd_wdata;
  logic              icb_rsp_valid;
  logic              icb_rsp_ready;
  logic              icb_rsp_err;
  data_t             icb_rsp_rdata;
  logic [GPIO_W-1:0] gpio_a_i_ival;
  logic [GPIO_W-1:0] gpio_a_o_oval;
  logic [GPIO_W-1:0] gpio_a_o_oe;
  logic              ext_irq;
  logic              sft_irq;
  logic              tmr_irq;

  logic [31:0]       lfsr;
  int                errors;

  subsys_main #(
    .GPIO_W      (GPIO_W),
    .SYNC_STAGES (SYNC_STAGES)
  ) DUT (.*);

  always #2 hfclk = ~hfclk;

  //////////////////////////////
  // Random data
  //////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic rand_word(output data_t val);
    for (int i = 0; i < 32; i++) begin
      lfsr   = next_lfsr(lfsr);
      val[i] = lfsr[0];
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_on_failure();
    errors++;
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at first failure");
  endtask

  task automatic report_mismatch(input string what, input data_t got, input data_t exp);
    $display("Error at time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    stop_on_failure();
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    stop_on_failure();
  endtask

  task automatic expect_word(input string what, input data_t got, input data_t exp);
    assert (got === exp) else report_mismatch(what, got, exp);
  endtask

  task automatic expect_bit(input string what, input logic got, input logic exp);
    assert (got === exp) else report_mismatch(what, data_t'(got), data_t'(exp));
  endtask

  `include "tb_subsys_tasks.svh"

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    hfclk            = 1'b0;
    reset            = 1'b1;
    inspect_mode     = 1'b0;
    inspect_por_rst  = 1'b0;
    inspect_32k_clk  = 1'b0;
    inspect_jtag_clk = 1'b0;
    aon_wdg_irq_a    = 1'b0;
    aon_rtc_irq_a    = 1'b0;
    aon_rtc_toggle_a = 1'b0;
    tm_stop          = 1'b0;
    icb_cmd_valid    = 1'b0;
    icb_cmd_addr     = '0;
    icb_cmd_read     = 1'b0;
    icb_cmd_wdata    = '0;
    icb_rsp_ready    = 1'b1;
    gpio_a_i_ival    = '0;
    lfsr             = 32'h8800cdf8;
    errors           = 0;

    repeat (16) @(posedge hfclk);
    reset <= 1'b0;

    register_round_trip();
    decode_error_backpressure();
    clint_interrupts();
    plic_claims();
    gpio_input_irq();
    inspect_override();

    repeat (2) @(posedge hfclk);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+verification
common/icb_pkg.sv
common/perip_pkg.sv
common/icb_if.sv
icb_fabric/icb_splitter.sv
perips/clint.sv
perips/plic.sv
perips/gpio.sv
hdl/subsys_main.sv
verification/tb_subsys_main.sv

//--- Makefile
# Verilator build and run of the subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_subsys_main
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
